//--- hw/conv_pkg.sv
package conv_pkg;

  localparam int PIX_W   = 8;
  localparam int COEF_W  = 8;
  localparam int PROD_W  = PIX_W + COEF_W;
  localparam int SUM_W   = 21;  // 25 * 255 * 255 needs 21 bits
  localparam int TAPS    = 25;
  localparam int WIDTH_W = 12;

  localparam logic [7:0] REG_CTRL    = 8'h00;
  localparam logic [7:0] REG_KERNEL0 = 8'h04;
  localparam logic [7:0] REG_KERNEL1 = 8'h08;
  localparam logic [7:0] REG_KERNEL2 = 8'h0C;
  localparam logic [7:0] REG_KERNEL3 = 8'h10;
  localparam logic [7:0] REG_KERNEL4 = 8'h14;
  localparam logic [7:0] REG_KERNEL5 = 8'h18;
  localparam logic [7:0] REG_KERNEL6 = 8'h1C;  // Holds tap 24 only

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic             valid;
    logic [PIX_W-1:0] pixel;
  } pix_stream_t;

  typedef struct packed {
    logic             valid;
    logic [SUM_W-1:0] sum;
  } res_stream_t;

  typedef logic [TAPS-1:0][COEF_W-1:0] kernel_t;
  typedef logic [TAPS-1:0][PIX_W-1:0]  window_t;  // Row-major order with tap 0 as the oldest pixel
  typedef logic [TAPS-1:0][PROD_W-1:0] prod_vec_t;

  typedef struct packed {
    logic [3:0]         rsvd_hi;
    logic [WIDTH_W-1:0] width;
    logic [14:0]        rsvd_lo;
    logic               enable;
  } ctrl_word_t;

  // One register word, read as coefficients or as control fields by address
  typedef union packed {
    logic [3:0][COEF_W-1:0] coef;
    ctrl_word_t             ctrl;
  } reg_word_u;

endpackage

//--- hw/conv_apb_regs.sv
`timescale 1ns/1ps

module conv_apb_regs import conv_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp,
  output kernel_t            kernel,
  output logic               enable,
  output logic [WIDTH_W-1:0] width,
  output logic               frame_restart
);

  logic      access;
  logic      wr_en;
  logic      is_ctrl;
  logic      is_kernel;
  logic      addr_err;
  logic [2:0] kword;
  reg_word_u wr_word;
  reg_word_u rd_word;

  assign access    = apb_req.psel && apb_req.penable;
  assign wr_en     = access && apb_req.pwrite;
  assign is_ctrl   = (apb_req.paddr == REG_CTRL);
  assign is_kernel = (apb_req.paddr >= REG_KERNEL0) && (apb_req.paddr <= REG_KERNEL6) &&
                     (apb_req.paddr[1:0] == 2'b00);
  assign addr_err  = access && (apb_req.paddr > REG_KERNEL6);
  assign kword     = apb_req.paddr[4:2] - 3'd1;  // Kernel word 0 sits at 0x04
  assign wr_word   = apb_req.pwdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      kernel        <= '0;
      enable        <= 1'b0;
      width         <= '0;
      frame_restart <= 1'b0;
    end else begin
      frame_restart <= wr_en && is_ctrl;
      if (wr_en && is_ctrl) begin
        enable <= wr_word.ctrl.enable;
        width  <= wr_word.ctrl.width;
      end
      if (wr_en && is_kernel) begin
        for (int b = 0; b < 4; b++) begin
          if (kword * 4 + b < TAPS) begin
            kernel[kword * 4 + b] <= wr_word.coef[b];
          end
        end
      end
    end
  end

  always_comb begin
    rd_word = '0;
    if (is_ctrl) begin
      rd_word.ctrl.enable = enable;
      rd_word.ctrl.width  = width;
    end else if (is_kernel) begin
      for (int b = 0; b < 4; b++) begin
        if (kword * 4 + b < TAPS) begin
          rd_word.coef[b] = kernel[kword * 4 + b];  // Missing taps stay 0
        end
      end
    end
  end

  always_comb begin
    apb_rsp.prdata  = rd_word;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = addr_err;
  end

  // The master never raises penable outside a selected transfer
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel
  );

endmodule

//--- hw/conv_line_buffer.sv
`timescale 1ns/1ps

module conv_line_buffer import conv_pkg::*; #(
  parameter int MAX_WIDTH = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               pipe_en,
  input  logic               frame_restart,
  input  logic [WIDTH_W-1:0] width,
  input  pix_stream_t        pix,
  input  logic               accept,
  output window_t            window,
  output logic               win_valid
);

  localparam int K     = 5;
  localparam int LINES = K - 1;
  localparam int COL_W = $clog2(MAX_WIDTH);

  logic [PIX_W-1:0]         line_mem [LINES][MAX_WIDTH];
  logic [K-1:0][PIX_W-1:0]  new_col;
  logic [WIDTH_W-1:0]       col;
  logic [WIDTH_W-1:0]       col_cur;
  logic [2:0]               row;
  logic [2:0]               row_cur;
  logic [COL_W-1:0]         col_idx;
  logic                     last_col;
  logic                     full_window;

  // A pixel arriving with the restart pulse already belongs to the new frame
  always_comb begin
    col_cur = frame_restart ? '0 : col;
    row_cur = frame_restart ? '0 : row;
  end

  assign col_idx     = col_cur[COL_W-1:0];
  assign last_col    = (col_cur == width - 1'b1);
  assign full_window = (col_cur >= 4) && (row_cur >= 3'd4);

  // line_mem[0] is the previous row, line_mem[3] the oldest
  always_comb begin
    for (int r = 0; r < LINES; r++) begin
      new_col[r] = line_mem[LINES-1-r][col_idx];
    end
    new_col[K-1] = pix.pixel;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      line_mem[0][col_idx] <= pix.pixel;
      for (int m = 1; m < LINES; m++) begin
        line_mem[m][col_idx] <= line_mem[m-1][col_idx];
      end
    end
  end

  // Shift the window one column left and load the new column on the right
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int r = 0; r < K; r++) begin
        for (int c = 0; c < K - 1; c++) begin
          window[r*K + c] <= window[r*K + c + 1];
        end
        window[r*K + K - 1] <= new_col[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      col       <= '0;
      row       <= '0;
      win_valid <= 1'b0;
    end else begin
      if (accept) begin
        if (last_col) begin
          col <= '0;
          // Only rows 0 to 4 matter, so the count stops at 4
          row <= (row_cur == 3'd4) ? row_cur : row_cur + 3'd1;
        end else begin
          col <= col_cur + 1'b1;
          row <= row_cur;
        end
      end else if (frame_restart) begin
        col <= '0;
        row <= '0;
      end
      if (pipe_en) begin
        win_valid <= accept && full_window;
      end
    end
  end

  // Software must program a usable width before enabling the stream
  a_width_in_range : assert property (
    @(posedge clk) disable iff (reset)
    accept |-> (width >= 5) && (width <= MAX_WIDTH)
  );

endmodule

//--- hw/conv_mac_array.sv
`timescale 1ns/1ps

module conv_mac_array import conv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      pipe_en,
  input  window_t   window,
  input  logic      win_valid,
  input  kernel_t   kernel,
  output prod_vec_t prod,
  output logic      prod_valid
);

  prod_vec_t prod_next;

  // Each tap is an unsigned 8x8 multiply, one per DSP slice
  always_comb begin
    for (int i = 0; i < TAPS; i++) begin
      prod_next[i] = PROD_W'(window[i]) * PROD_W'(kernel[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_en) begin
      prod <= prod_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else if (pipe_en) begin
      prod_valid <= win_valid;
    end
  end

endmodule

//--- hw/conv_adder_tree.sv
`timescale 1ns/1ps

module conv_adder_tree import conv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        pipe_en,
  input  prod_vec_t   prod,
  input  logic        prod_valid,
  output res_stream_t res
);

  localparam int LEVELS = 5;
  localparam int L1_W   = PROD_W + 1;
  localparam int L2_W   = PROD_W + 2;
  localparam int L3_W   = PROD_W + 3;
  localparam int L4_W   = PROD_W + 4;

  logic [L1_W-1:0]   lvl1 [13];
  logic [L2_W-1:0]   lvl2 [7];
  logic [L3_W-1:0]   lvl3 [4];
  logic [L4_W-1:0]   lvl4 [2];
  logic [SUM_W-1:0]  sum_q;
  logic [LEVELS-1:0] vld_pipe;

  // Pairs add at each level, an odd operand rides through unchanged
  always_ff @(posedge clk) begin
    if (pipe_en) begin
      for (int i = 0; i < 12; i++) begin
        lvl1[i] <= L1_W'(prod[2*i]) + L1_W'(prod[2*i + 1]);
      end
      lvl1[12] <= L1_W'(prod[24]);

      for (int i = 0; i < 6; i++) begin
        lvl2[i] <= L2_W'(lvl1[2*i]) + L2_W'(lvl1[2*i + 1]);
      end
      lvl2[6] <= L2_W'(lvl1[12]);

      for (int i = 0; i < 3; i++) begin
        lvl3[i] <= L3_W'(lvl2[2*i]) + L3_W'(lvl2[2*i + 1]);
      end
      lvl3[3] <= L3_W'(lvl2[6]);

      for (int i = 0; i < 2; i++) begin
        lvl4[i] <= L4_W'(lvl3[2*i]) + L4_W'(lvl3[2*i + 1]);
      end

      sum_q <= SUM_W'(lvl4[0]) + SUM_W'(lvl4[1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else if (pipe_en) begin
      vld_pipe <= {vld_pipe[LEVELS-2:0], prod_valid};
    end
  end

  always_comb begin
    res.valid = vld_pipe[LEVELS-1];
    res.sum   = sum_q;
  end

  a_res_valid_known : assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(res.valid)
  );

endmodule

//--- hw/conv_engine_top.sv
`timescale 1ns/1ps

module conv_engine_top import conv_pkg::*; #(
  parameter int MAX_WIDTH = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  input  pix_stream_t pix_in,
  output logic        pix_ready,
  output res_stream_t res_out,
  input  logic        res_ready
);

  kernel_t            kernel;
  logic               enable;
  logic [WIDTH_W-1:0] width;
  logic               frame_restart;
  logic               pipe_en;
  logic               accept;
  window_t            window;
  logic               win_valid;
  prod_vec_t          prod;
  logic               prod_valid;

  // The whole pipeline moves as one, stalled only by a held result
  assign pipe_en   = res_ready || !res_out.valid;
  assign pix_ready = pipe_en && enable;
  assign accept    = pix_in.valid && pix_ready;

  conv_apb_regs i_regs (
    .clk           (clk),
    .reset         (reset),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .kernel        (kernel),
    .enable        (enable),
    .width         (width),
    .frame_restart (frame_restart)
  );

  conv_line_buffer #(
    .MAX_WIDTH (MAX_WIDTH)
  ) i_line_buffer (
    .clk           (clk),
    .reset         (reset),
    .pipe_en       (pipe_en),
    .frame_restart (frame_restart),
    .width         (width),
    .pix           (pix_in),
    .accept        (accept),
    .window        (window),
    .win_valid     (win_valid)
  );

  conv_mac_array i_mac_array (
    .clk        (clk),
    .reset      (reset),
    .pipe_en    (pipe_en),
    .window     (window),
    .win_valid  (win_valid),
    .kernel     (kernel),
    .prod       (prod),
    .prod_valid (prod_valid)
  );

  conv_adder_tree i_adder_tree (
    .clk        (clk),
    .reset      (reset),
    .pipe_en    (pipe_en),
    .prod       (prod),
    .prod_valid (prod_valid),
    .res        (res_out)
  );

  // A result not taken stays put until the sink accepts it
  a_res_held_on_stall : assert property (
    @(posedge clk) disable iff (reset)
    res_out.valid && !res_ready |=> res_out.valid && $stable(res_out.sum)
  );

endmodule

//--- include/conv_tb_ref.svh
`ifndef CONV_TB_REF_SVH
`define CONV_TB_REF_SVH

// Image stored as [y][x], kernel taps in row-major order
logic [7:0] img [16][16];
logic [7:0] kern [25];
int img_w;
int img_h;
int exp_q [$];  // Expected sums in raster order

// Sum of the 5x5 window whose bottom-right pixel is (y, x)
function automatic int conv_ref(input int y, input int x);
  int acc;
  acc = 0;
  for (int r = 0; r < 5; r++) begin
    for (int c = 0; c < 5; c++) begin
      acc += int'(img[y - 4 + r][x - 4 + c]) * int'(kern[r * 5 + c]);
    end
  end
  return acc;
endfunction

task automatic fill_random_image(input int w, input int h);
  img_w = w;
  img_h = h;
  for (int y = 0; y < h; y++) begin
    for (int x = 0; x < w; x++) begin
      img[y][x] = 8'($random(seed));
    end
  end
endtask

task automatic fill_const_image(input int w, input int h, input logic [7:0] val);
  img_w = w;
  img_h = h;
  for (int y = 0; y < h; y++) begin
    for (int x = 0; x < w; x++) begin
      img[y][x] = val;
    end
  end
endtask

task automatic random_kernel();
  for (int i = 0; i < 25; i++) begin
    kern[i] = 8'($random(seed));
  end
endtask

// Only windows that lie fully inside the image produce a result
task automatic queue_ref_sums();
  for (int y = 4; y < img_h; y++) begin
    for (int x = 4; x < img_w; x++) begin
      exp_q.push_back(conv_ref(y, x));
    end
  end
endtask

`endif

//--- verif/conv_tb.sv
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

  localparam int MAX_WIDTH   = 16;
  localparam int CYCLE_LIMIT = 20000;  // Far longer than all tests together

  logic        clk = 1'b0;
  logic        reset;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  pix_stream_t pix_in;
  logic        pix_ready;
  res_stream_t res_out;
  logic        res_ready;

  integer seed = 32'h149b_66d9;
  int     cycles = 0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     test_err0 = 0;
  int     exp_sum;
  int     bp_rnd;
  bit     bp_mode = 1'b0;

  `include "conv_tb_ref.svh"

  conv_engine_top #(
    .MAX_WIDTH (MAX_WIDTH)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .pix_in    (pix_in),
    .pix_ready (pix_ready),
    .res_out   (res_out),
    .res_ready (res_ready)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // The sink holds ready high unless back-pressure is on
  always @(negedge clk) begin
    bp_rnd = $random(seed);
  end

  always @(posedge clk) begin
    #1;
    res_ready = bp_mode ? bp_rnd[0] : 1'b1;
  end

  // A result is taken at the next rising edge, so it is checked here
  always @(negedge clk) begin
    if (!reset && res_out.valid && res_ready) begin
      if (exp_q.size() == 0) begin
        $display("extra result %0d at %0t arrived with nothing left to expect",
                 res_out.sum, $time);
        errors++;
      end else begin
        exp_sum = exp_q.pop_front();
        if (res_out.sum !== exp_sum) begin
          $display("error at %0t: result expected %0d got %0d", $time, exp_sum, res_out.sum);
          errors++;
        end
      end
    end
  end

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected,
                           input logic exp_err);
    logic [31:0] data;
    logic        err;
    logic        rdy;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    rdy  = apb_rsp.pready;
    @(posedge clk);
    #1;
    apb_req = '0;
    if (rdy !== 1'b1) begin
      $display("error at %0t: pready at 0x%02h expected 1 got %0b", $time, addr, rdy);
      errors++;
    end
    if (err !== exp_err) begin
      $display("error at %0t: pslverr at 0x%02h expected %0b got %0b", $time, addr, exp_err, err);
      errors++;
    end
    if (!exp_err && data !== expected) begin
      $display("error at %0t: register 0x%02h expected 0x%08h got 0x%08h",
               $time, addr, expected, data);
      errors++;
    end
  endtask

  task automatic write_kernel();
    reg_word_u word;
    for (int w = 0; w < 7; w++) begin
      word = '0;
      for (int b = 0; b < 4; b++) begin
        if (w * 4 + b < TAPS) begin
          word.coef[b] = kern[w * 4 + b];
        end
      end
      apb_write(REG_KERNEL0 + 8'(4 * w), word);
    end
  endtask

  // Writing the control word also restarts the frame at row 0, column 0
  task automatic start_frame(input int w);
    reg_word_u word;
    word             = '0;
    word.ctrl.enable = 1'b1;
    word.ctrl.width  = WIDTH_W'(w);
    apb_write(REG_CTRL, word);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic stream_image();
    bit took;
    for (int y = 0; y < img_h; y++) begin
      for (int x = 0; x < img_w; x++) begin
        pix_in.valid = 1'b1;
        pix_in.pixel = img[y][x];
        took = 1'b0;
        while (!took) begin
          @(negedge clk);
          took = pix_ready;
          @(posedge clk);
          #1;
        end
      end
    end
    pix_in.valid = 1'b0;
  endtask

  task automatic drain_results(input string name);
    int wait_cycles;
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < 400) begin
      @(posedge clk);
      wait_cycles++;
    end
    #1;
    if (exp_q.size() != 0) begin
      $display("%s: %0d results never arrived", name, exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
    repeat (12) @(posedge clk);  // Room for any result beyond the expected count
    #1;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_err0);
      tests_failed++;
    end
    test_err0 = errors;
  endtask

  initial begin
    logic [31:0] reg_vals [8];
    integer      seed_t3;
    reset     = 1'b1;
    apb_req   = '0;
    pix_in    = '0;
    res_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (2) @(posedge clk);
    #1;

    for (int i = 0; i < 8; i++) begin
      reg_vals[i] = $random(seed);
    end
    apb_write(REG_CTRL, reg_vals[0]);
    for (int w = 0; w < 7; w++) begin
      apb_write(REG_KERNEL0 + 8'(4 * w), reg_vals[w + 1]);
    end
    check_reg(REG_CTRL, reg_vals[0] & 32'h0FFF_0001, 1'b0);  // Enable and width only
    for (int w = 0; w < 7; w++) begin
      check_reg(REG_KERNEL0 + 8'(4 * w), (w == 6) ? (reg_vals[7] & 32'hFF) : reg_vals[w + 1],
                1'b0);
    end
    check_reg(8'h20, '0, 1'b1);
    finish_test("registers");

    for (int i = 0; i < TAPS; i++) begin
      kern[i] = 8'd0;
    end
    kern[12] = 8'd1;
    fill_random_image(9, 8);
    for (int y = 4; y < 8; y++) begin
      for (int x = 4; x < 9; x++) begin
        exp_q.push_back(img[y - 2][x - 2]);  // Centre of the window
      end
    end
    write_kernel();
    start_frame(9);
    stream_image();
    drain_results("identity kernel");
    finish_test("identity kernel");

    seed_t3 = seed;  // Replayed later to regenerate the same data
    random_kernel();
    fill_random_image(12, 7);
    queue_ref_sums();
    write_kernel();
    start_frame(12);
    stream_image();
    drain_results("random kernel");
    finish_test("random kernel");

    for (int i = 0; i < TAPS; i++) begin
      kern[i] = 8'hFF;
    end
    fill_const_image(7, 6, 8'hFF);
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(25 * 255 * 255);
    end
    write_kernel();
    start_frame(7);
    stream_image();
    drain_results("full range");
    finish_test("full range");

    seed = seed_t3;
    random_kernel();
    fill_random_image(12, 7);
    queue_ref_sums();
    write_kernel();
    start_frame(12);
    bp_mode = 1'b1;
    stream_image();
    drain_results("back-pressure");
    bp_mode = 1'b0;
    finish_test("back-pressure");

    fill_random_image(5, 6);
    queue_ref_sums();
    start_frame(5);
    stream_image();
    drain_results("width change");
    finish_test("width change");

    $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/conv_pkg.sv
hw/conv_apb_regs.sv
hw/conv_line_buffer.sv
hw/conv_mac_array.sv
hw/conv_adder_tree.sv
hw/conv_engine_top.sv
verif/conv_tb.sv
